// File: Makefile
# Verilator simulation of the hash table engine
# every variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_ht_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+include
source/ht_pkg.sv
source/ht_ram.sv
source/ht_delay.sv
source/ht_hash_calc.sv
source/head_table.sv
source/ht_result_calc.sv
source/ht_top.sv
sim/tb_clock_gen.sv
sim/tb_ht_top.sv

// File: include/ht_defs.svh
/*
  width macros for the hash table engine
  key, value and bucket address widths
*/

`ifndef HT_DEFS_SVH
`define HT_DEFS_SVH

// ------------------------------
// data widths
// ------------------------------

// key carried by every command
`define HT_KEY_W    16

// value stored with a key
`define HT_VALUE_W  16

// bucket address, 256 buckets with one entry each
`define HT_BUCKET_W 8

`endif

// File: sim/tb_clock_gen.sv
/*
  testbench clock and reset source
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o <= 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o <= ~clk_o;
  end

  // reset drops on a rising edge after the hold count
  initial
  begin
    rst_o <= 1'b1;
    repeat (RESET_CYCLES)
      @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/tb_ht_top.sv
/*
  testbench for the hash table engine
  directed test tasks, scoreboard with a reference table
  random back-pressure, timeout and final report
*/

`timescale 1ns/1ps
`default_nettype none

`include "ht_defs.svh"

module tb_ht_top
  import ht_pkg::*;
();

  localparam int CYCLE_LIMIT = 4000;
  localparam int NUM_RANDOM  = 200;

  logic                   clk;
  logic                   rst;
  ht_opcode_t             cmd_opcode;
  logic [`HT_KEY_W-1:0]   cmd_key;
  logic [`HT_VALUE_W-1:0] cmd_value;
  logic                   cmd_valid;
  logic                   cmd_ready;
  ht_result_t             res_code;
  logic [`HT_KEY_W-1:0]   res_key;
  logic [`HT_VALUE_W-1:0] res_value;
  logic                   res_valid;
  logic                   res_ready;

  // reference table with one entry per bucket
  logic                   ref_valid [256];
  logic [`HT_KEY_W-1:0]   ref_key   [256];
  logic [`HT_VALUE_W-1:0] ref_value [256];

  ht_result_t             exp_code_q  [$];
  logic [`HT_KEY_W-1:0]   exp_key_q   [$];
  logic [`HT_VALUE_W-1:0] exp_value_q [$];
  ht_result_t             exp_code;
  logic [`HT_KEY_W-1:0]   exp_key;
  logic [`HT_VALUE_W-1:0] exp_value;

  logic                   ready_pattern [1024];
  logic                   ready_random;
  logic [9:0]             ready_idx;
  integer                 seed;
  int                     cycles = 0;
  int                     checks = 0;
  int                     errors = 0;

  tb_clock_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (8)
  ) clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  ht_top uut (
    .clk_i        (clk),
    .rst_i        (rst),
    .cmd_opcode_i (cmd_opcode),
    .cmd_key_i    (cmd_key),
    .cmd_value_i  (cmd_value),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .res_code_o   (res_code),
    .res_key_o    (res_key),
    .res_value_o  (res_value),
    .res_valid_o  (res_valid),
    .res_ready_i  (res_ready)
  );

  // low byte ^ high byte ^ high byte rotated left by 3
  function automatic logic [`HT_BUCKET_W-1:0] bucket_of(input logic [`HT_KEY_W-1:0] key);
    return key[7:0] ^ key[15:8] ^ {key[12:8], key[15:13]};
  endfunction

  // key with the given high byte that lands in the same bucket as key
  function automatic logic [`HT_KEY_W-1:0] colliding_key(input logic [`HT_KEY_W-1:0] key,
                                                         input logic [7:0] hi);
    return {hi, bucket_of(key) ^ hi ^ {hi[4:0], hi[7:5]}};
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------

  task automatic model_command(input ht_opcode_t op, input logic [`HT_KEY_W-1:0] key,
                               input logic [`HT_VALUE_W-1:0] value);
    logic [`HT_BUCKET_W-1:0] b;
    logic                    hit;
    ht_result_t              code;
    logic [`HT_VALUE_W-1:0]  rv;
    b    = bucket_of(key);
    hit  = ref_valid[b] && (ref_key[b] == key);
    code = RES_NOT_FOUND;
    rv   = '0;
    case (op)
      OP_SEARCH:
        if (hit)
        begin
          code = RES_FOUND;
          rv   = ref_value[b];
        end
      OP_INSERT:
        if (!ref_valid[b] || hit)
        begin
          code         = hit ? RES_UPDATED : RES_INSERTED;
          rv           = value;
          ref_valid[b] = 1'b1;
          ref_key[b]   = key;
          ref_value[b] = value;
        end
        else
        begin
          code = RES_COLLISION;
          rv   = ref_value[b];
        end
      OP_DELETE:
        if (hit)
        begin
          code         = RES_DELETED;
          rv           = ref_value[b];
          ref_valid[b] = 1'b0;
        end
      default:
        code = RES_NOT_FOUND;
    endcase
    exp_code_q.push_back(code);
    exp_key_q.push_back(key);
    exp_value_q.push_back(rv);
  endtask

  // ------------------------------
  // scoreboard
  // ------------------------------

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 256; i++)
        ref_valid[i] = 1'b0;
    end
    else
    begin
      // a result is checked before the command of the same edge enters the model
      if (res_valid !== 1'b0 && exp_code_q.size() == 0)
      begin
        $display("ERROR at %0t: res_valid_o is %b with no command outstanding, key %h",
                 $time, res_valid, res_key);
        errors++;
      end
      else if (res_valid && res_ready)
      begin
        exp_code  = exp_code_q.pop_front();
        exp_key   = exp_key_q.pop_front();
        exp_value = exp_value_q.pop_front();
        checks++;
        if (res_code !== exp_code)
        begin
          $display("CHECK FAILED t=%0t res_code_o expected %0d got %0d",
                   $time, exp_code, res_code);
          errors++;
        end
        if (res_key !== exp_key)
        begin
          $display("CHECK FAILED t=%0t res_key_o expected %h got %h", $time, exp_key, res_key);
          errors++;
        end
        if (res_value !== exp_value)
        begin
          $display("CHECK FAILED t=%0t res_value_o expected %h got %h",
                   $time, exp_value, res_value);
          errors++;
        end
      end
      if (cmd_valid && cmd_ready)
        model_command(cmd_opcode, cmd_key, cmd_value);
    end
  end

  // result side ready stays high unless the random pattern is switched on
  initial
  begin
    res_ready <= 1'b1;
    ready_idx <= '0;
    forever
    begin
      @(posedge clk);
      ready_idx <= ready_idx + 10'd1;
      res_ready <= ready_random ? ready_pattern[ready_idx] : 1'b1;
    end
  end

  task automatic print_counts();
    $display("results checked %0d, outstanding %0d, errors %0d",
             checks, exp_code_q.size(), errors);
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, %0d results never arrived",
               cycles, exp_code_q.size());
      print_counts();
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  task automatic send_cmd(input ht_opcode_t op, input logic [`HT_KEY_W-1:0] key,
                          input logic [`HT_VALUE_W-1:0] value);
    cmd_opcode <= op;
    cmd_key    <= key;
    cmd_value  <= value;
    cmd_valid  <= 1'b1;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (exp_code_q.size() != 0)
      @(posedge clk);
  endtask

  task automatic test_empty_search();
    repeat (4)
      @(posedge clk);
    send_cmd(OP_SEARCH, 16'h0000, 16'h1111);
    send_cmd(OP_SEARCH, 16'h1234, 16'h2222);
    send_cmd(OP_SEARCH, 16'hbeef, 16'h3333);
    send_cmd(OP_SEARCH, 16'hffff, 16'h4444);
    wait_drain();
  endtask

  task automatic test_insert_update();
    logic [31:0] r;
    r = $random(seed);
    send_cmd(OP_INSERT, 16'h1234, r[15:0]);
    wait_drain();
    send_cmd(OP_SEARCH, 16'h1234, 16'h0000);
    send_cmd(OP_INSERT, 16'h1234, r[31:16]);
    wait_drain();
    send_cmd(OP_SEARCH, 16'h1234, 16'h0000);
    wait_drain();
  endtask

  task automatic test_collision();
    logic [`HT_KEY_W-1:0] other;
    other = colliding_key(16'h4a5b, 8'hc3);
    send_cmd(OP_INSERT, 16'h4a5b, 16'h5151);
    wait_drain();
    send_cmd(OP_INSERT, other, 16'h7777);
    wait_drain();
    send_cmd(OP_SEARCH, 16'h4a5b, 16'h0000);
    send_cmd(OP_SEARCH, other, 16'h0000);
    wait_drain();
  endtask

  task automatic test_delete();
    send_cmd(OP_DELETE, 16'h4a5b, 16'h0000);
    wait_drain();
    send_cmd(OP_SEARCH, 16'h4a5b, 16'h5555);
    send_cmd(OP_DELETE, 16'h4a5b, 16'h6666);
    send_cmd(OP_DELETE, 16'h9999, 16'h8888);
    wait_drain();
  endtask

  // same bucket commands on consecutive edges
  task automatic test_back_to_back();
    logic [`HT_KEY_W-1:0] other;
    other = colliding_key(16'h3c5a, 8'h77);
    send_cmd(OP_INSERT, 16'h3c5a, 16'h0101);
    send_cmd(OP_SEARCH, 16'h3c5a, 16'h0000);
    send_cmd(OP_INSERT, other, 16'h0202);
    send_cmd(OP_INSERT, 16'h3c5a, 16'h0303);
    send_cmd(OP_SEARCH, 16'h3c5a, 16'h0000);
    send_cmd(OP_DELETE, 16'h3c5a, 16'h0000);
    send_cmd(OP_SEARCH, 16'h3c5a, 16'h0505);
    send_cmd(OP_INSERT, other, 16'h0404);
    send_cmd(OP_SEARCH, other, 16'h0000);
    wait_drain();
  endtask

  task automatic test_random_stream();
    logic [31:0] r;
    logic [31:0] v;
    ht_opcode_t  op;
    for (int i = 0; i < 1024; i++)
    begin
      r = $random(seed);
      ready_pattern[i] = r[4];
    end
    ready_random <= 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      r  = $random(seed);
      v  = $random(seed);
      op = (r[17:16] == 2'd3) ? OP_SEARCH : ht_opcode_t'(r[17:16]);
      // narrow key space so hits, collisions and deletes all show up
      send_cmd(op, {4'h0, r[11:8], 4'h0, r[3:0]}, v[15:0]);
      if (r[20] && r[21])
        @(posedge clk);
    end
    wait_drain();
    ready_random <= 1'b0;
  endtask

  initial
  begin
    seed = 48638;
    cmd_opcode   <= OP_SEARCH;
    cmd_key      <= '0;
    cmd_value    <= '0;
    cmd_valid    <= 1'b0;
    ready_random <= 1'b0;
    @(posedge clk);
    while (rst)
      @(posedge clk);

    test_empty_search();
    test_insert_update();
    test_collision();
    test_delete();
    test_back_to_back();
    test_random_stream();

    repeat (10)
      @(posedge clk);
    print_counts();
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/head_table.sv
/*
  head table stage
  bucket RAM read, write hazard stall, last write forwarding
*/

`timescale 1ns/1ps
`default_nettype none

`include "ht_defs.svh"

module head_table
  import ht_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,

  input  wire ht_pdata_t              pdata_in_i,
  input  wire logic                   pdata_in_valid_i,
  output logic                        pdata_in_ready_o,

  output ht_pdata_t                   pdata_out_o,
  output logic                        pdata_out_valid_o,
  input  wire logic                   pdata_out_ready_i,

  input  wire logic                   tbl_wr_en_i,
  input  wire logic [`HT_BUCKET_W-1:0] tbl_wr_bucket_i,
  input  wire ht_entry_t              tbl_wr_entry_i,
  input  wire logic                   tbl_wr_valid_i
);

  logic                    rd_en;
  ht_entry_t               rd_entry;
  logic                    rd_entry_val;

  logic                    d1_ready;
  ht_pdata_t               d1_pdata;

  logic [`HT_BUCKET_W-1:0] prev_bucket;
  logic                    prev_wr_pending;
  logic                    hazard;

  logic                    last_wr_en;
  logic [`HT_BUCKET_W-1:0] last_wr_bucket;
  ht_entry_t               last_wr_entry;
  logic                    last_wr_valid;

  // ------------------------------
  // hazard detection
  // ------------------------------

  // an insert/delete accepted on the last edge has not reached the result stage yet
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      prev_wr_pending <= 1'b0;
    else
      prev_wr_pending <= rd_en && (pdata_in_i.cmd.opcode inside {OP_INSERT, OP_DELETE});
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_en)
      prev_bucket <= pdata_in_i.bucket;
  end

  assign hazard = prev_wr_pending && (prev_bucket == pdata_in_i.bucket);

  assign pdata_in_ready_o = d1_ready && !hazard;
  assign rd_en            = pdata_in_valid_i && pdata_in_ready_o;

  // ------------------------------
  // table and pipeline register
  // ------------------------------

  ht_ram #(
    .DATA_W     ($bits(ht_entry_t)),
    .ADDR_W     (`HT_BUCKET_W)
  ) bucket_ram (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_en_i    (rd_en),
    .rd_addr_i  (pdata_in_i.bucket),
    .rd_data_o  (rd_entry),
    .rd_valid_o (rd_entry_val),
    .wr_en_i    (tbl_wr_en_i),
    .wr_addr_i  (tbl_wr_bucket_i),
    .wr_data_i  (tbl_wr_entry_i),
    .wr_valid_i (tbl_wr_valid_i)
  );

  ht_delay #(
    .T       (ht_pdata_t)
  ) pdata_d1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (pdata_in_i),
    .valid_i (pdata_in_valid_i && !hazard),
    .ready_o (d1_ready),
    .data_o  (d1_pdata),
    .valid_o (pdata_out_valid_o),
    .ready_i (pdata_out_ready_i)
  );

  // ------------------------------
  // last write forwarding
  // ------------------------------

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      last_wr_en <= 1'b0;
    else if (tbl_wr_en_i)
      last_wr_en <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (tbl_wr_en_i)
    begin
      last_wr_bucket <= tbl_wr_bucket_i;
      last_wr_entry  <= tbl_wr_entry_i;
      last_wr_valid  <= tbl_wr_valid_i;
    end
  end

  // the newest write wins over a RAM word read before it landed
  always_comb
  begin
    pdata_out_o = d1_pdata;
    if (last_wr_en && (last_wr_bucket == d1_pdata.bucket))
    begin
      pdata_out_o.entry     = last_wr_entry;
      pdata_out_o.entry_val = last_wr_valid;
    end
    else
    begin
      pdata_out_o.entry     = rd_entry;
      pdata_out_o.entry_val = rd_entry_val;
    end
  end

  // a write op blocks a same bucket read on the very next edge
  a_no_read_on_hazard: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_en && (pdata_in_i.cmd.opcode inside {OP_INSERT, OP_DELETE})
    |=> !(rd_en && (pdata_in_i.bucket == $past(pdata_in_i.bucket))));

endmodule

`default_nettype wire

// File: source/ht_delay.sv
/*
  single register stage with valid/ready handshake
  payload type given by a type parameter
*/

`timescale 1ns/1ps
`default_nettype none

`include "ht_defs.svh"

module ht_delay
  import ht_pkg::*;
#(
  parameter type T = ht_cmd_t
) (
  input  wire logic clk_i,
  input  wire logic rst_i,

  input  wire T     data_i,
  input  wire logic valid_i,
  output logic      ready_o,

  output T          data_o,
  output logic      valid_o,
  input  wire logic ready_i
);

  logic load;

  // free when empty or when the held word leaves this cycle
  assign ready_o = !valid_o || ready_i;
  assign load    = valid_i && ready_o;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      valid_o <= 1'b0;
    else if (ready_o)
      valid_o <= valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
      data_o <= data_i;
  end

  // a stalled word must not change under the consumer
  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// File: source/ht_hash_calc.sv
/*
  hash stage
  registers the command and derives the bucket from its key
*/

`timescale 1ns/1ps
`default_nettype none

`include "ht_defs.svh"

module ht_hash_calc
  import ht_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,

  input  wire ht_opcode_t            cmd_opcode_i,
  input  wire logic [`HT_KEY_W-1:0]   cmd_key_i,
  input  wire logic [`HT_VALUE_W-1:0] cmd_value_i,
  input  wire logic                  cmd_valid_i,
  output logic                       cmd_ready_o,

  output ht_pdata_t                  pdata_o,
  output logic                       pdata_valid_o,
  input  wire logic                  pdata_ready_i
);

  ht_cmd_t cmd_in;
  ht_cmd_t cmd_q;

  // low byte ^ high byte ^ high byte rotated left by 3
  function automatic logic [`HT_BUCKET_W-1:0] calc_bucket(input logic [`HT_KEY_W-1:0] key);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = key[7:0];
    hi = key[15:8];
    return lo ^ hi ^ {hi[4:0], hi[7:5]};
  endfunction

  assign cmd_in.opcode = cmd_opcode_i;
  assign cmd_in.key    = cmd_key_i;
  assign cmd_in.value  = cmd_value_i;

  ht_delay #(
    .T       (ht_cmd_t)
  ) cmd_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (cmd_in),
    .valid_i (cmd_valid_i),
    .ready_o (cmd_ready_o),
    .data_o  (cmd_q),
    .valid_o (pdata_valid_o),
    .ready_i (pdata_ready_i)
  );

  // entry fields are filled in by the head table
  assign pdata_o.cmd       = cmd_q;
  assign pdata_o.bucket    = calc_bucket(cmd_q.key);
  assign pdata_o.entry     = '0;
  assign pdata_o.entry_val = 1'b0;

endmodule

`default_nettype wire

// File: source/ht_pkg.sv
/*
  hash table engine types
  opcode and result codes, table entry, command and pipeline data
*/

`default_nettype none

`include "ht_defs.svh"

package ht_pkg;

  typedef enum logic [1:0] {
    OP_SEARCH = 2'd0,
    OP_INSERT = 2'd1,
    OP_DELETE = 2'd2
  } ht_opcode_t;

  typedef enum logic [2:0] {
    RES_FOUND     = 3'd0,
    RES_NOT_FOUND = 3'd1,
    RES_INSERTED  = 3'd2,
    RES_UPDATED   = 3'd3,
    RES_COLLISION = 3'd4,
    RES_DELETED   = 3'd5
  } ht_result_t;

  // contents of one bucket
  typedef struct packed {
    logic [`HT_KEY_W-1:0]   key;
    logic [`HT_VALUE_W-1:0] value;
  } ht_entry_t;

  typedef struct packed {
    ht_opcode_t             opcode;
    logic [`HT_KEY_W-1:0]   key;
    logic [`HT_VALUE_W-1:0] value;
  } ht_cmd_t;

  // travels from the hash stage down to the result stage
  typedef struct packed {
    ht_cmd_t                 cmd;
    logic [`HT_BUCKET_W-1:0] bucket;
    ht_entry_t               entry;
    logic                    entry_val;
  } ht_pdata_t;

endpackage

`default_nettype wire

// File: source/ht_ram.sv
/*
  bucket RAM with one read and one write port
  registered read, valid bits cleared by reset
*/

`timescale 1ns/1ps
`default_nettype none

module ht_ram #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 8
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,

  input  wire logic              rd_en_i,
  input  wire logic [ADDR_W-1:0] rd_addr_i,
  output logic      [DATA_W-1:0] rd_data_o,
  output logic                   rd_valid_o,

  input  wire logic              wr_en_i,
  input  wire logic [ADDR_W-1:0] wr_addr_i,
  input  wire logic [DATA_W-1:0] wr_data_i,
  input  wire logic              wr_valid_i
);

  logic [DATA_W-1:0]    mem [2**ADDR_W];
  logic [2**ADDR_W-1:0] vld_q;

  // read before write on the same address gives the old word
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
    if (rd_en_i)
      rd_data_o <= mem[rd_addr_i];
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      vld_q      <= '0;
      rd_valid_o <= 1'b0;
    end
    else
    begin
      if (wr_en_i)
        vld_q[wr_addr_i] <= wr_valid_i;
      if (rd_en_i)
        rd_valid_o <= vld_q[rd_addr_i];
    end
  end

  a_rd_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_en_i |-> !$isunknown(rd_addr_i));

endmodule

`default_nettype wire

// File: source/ht_result_calc.sv
/*
  result stage
  key compare, result code, table write-back and result register
*/

`timescale 1ns/1ps
`default_nettype none

`include "ht_defs.svh"

module ht_result_calc
  import ht_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,

  input  wire ht_pdata_t              pdata_i,
  input  wire logic                   pdata_valid_i,
  output logic                        pdata_ready_o,

  output ht_result_t                  res_code_o,
  output logic [`HT_KEY_W-1:0]         res_key_o,
  output logic [`HT_VALUE_W-1:0]       res_value_o,
  output logic                        res_valid_o,
  input  wire logic                   res_ready_i,

  output logic                        tbl_wr_en_o,
  output logic [`HT_BUCKET_W-1:0]      tbl_wr_bucket_o,
  output ht_entry_t                   tbl_wr_entry_o,
  output logic                        tbl_wr_valid_o
);

  logic                   accept;
  logic                   match;
  logic                   wr_need;
  ht_result_t             code_nxt;
  logic [`HT_VALUE_W-1:0] value_nxt;

  assign pdata_ready_o = !res_valid_o || res_ready_i;
  assign accept        = pdata_valid_i && pdata_ready_o;
  assign match         = pdata_i.entry_val && (pdata_i.entry.key == pdata_i.cmd.key);

  always_comb
  begin
    code_nxt       = RES_NOT_FOUND;
    value_nxt      = '0;
    wr_need        = 1'b0;
    tbl_wr_valid_o = 1'b0;
    case (pdata_i.cmd.opcode)
      OP_SEARCH:
        if (match)
        begin
          code_nxt  = RES_FOUND;
          value_nxt = pdata_i.entry.value;
        end
      OP_INSERT:
        if (!pdata_i.entry_val || match)
        begin
          code_nxt       = match ? RES_UPDATED : RES_INSERTED;
          value_nxt      = pdata_i.cmd.value;
          wr_need        = 1'b1;
          tbl_wr_valid_o = 1'b1;
        end
        else
        begin
          // another key owns the bucket
          code_nxt  = RES_COLLISION;
          value_nxt = pdata_i.entry.value;
        end
      OP_DELETE:
        if (match)
        begin
          code_nxt  = RES_DELETED;
          value_nxt = pdata_i.entry.value;
          wr_need   = 1'b1;
        end
      default:
        code_nxt = RES_NOT_FOUND;
    endcase
  end

  // write-back lands on the same edge that loads the result
  assign tbl_wr_en_o          = accept && wr_need;
  assign tbl_wr_bucket_o      = pdata_i.bucket;
  assign tbl_wr_entry_o.key   = pdata_i.cmd.key;
  assign tbl_wr_entry_o.value = pdata_i.cmd.value;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      res_valid_o <= 1'b0;
    else if (pdata_ready_o)
      res_valid_o <= pdata_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      res_code_o  <= code_nxt;
      res_key_o   <= pdata_i.cmd.key;
      res_value_o <= value_nxt;
    end
  end

  a_wr_only_modify: assert property (@(posedge clk_i) disable iff (rst_i)
    tbl_wr_en_o |=> res_valid_o && (res_code_o inside {RES_INSERTED, RES_UPDATED, RES_DELETED}));

endmodule

`default_nettype wire

// File: source/ht_top.sv
/*
  hash table engine top level
  hash stage, head table and result stage
*/

`timescale 1ns/1ps
`default_nettype none

`include "ht_defs.svh"

module ht_top
  import ht_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,

  input  wire ht_opcode_t            cmd_opcode_i,
  input  wire logic [`HT_KEY_W-1:0]   cmd_key_i,
  input  wire logic [`HT_VALUE_W-1:0] cmd_value_i,
  input  wire logic                  cmd_valid_i,
  output logic                       cmd_ready_o,

  output ht_result_t                 res_code_o,
  output logic [`HT_KEY_W-1:0]        res_key_o,
  output logic [`HT_VALUE_W-1:0]      res_value_o,
  output logic                       res_valid_o,
  input  wire logic                  res_ready_i
);

  ht_pdata_t               hash_pdata;
  logic                    hash_valid;
  logic                    hash_ready;

  ht_pdata_t               head_pdata;
  logic                    head_valid;
  logic                    head_ready;

  logic                    tbl_wr_en;
  logic [`HT_BUCKET_W-1:0] tbl_wr_bucket;
  ht_entry_t               tbl_wr_entry;
  logic                    tbl_wr_valid;

  ht_hash_calc hash_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_opcode_i  (cmd_opcode_i),
    .cmd_key_i     (cmd_key_i),
    .cmd_value_i   (cmd_value_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .pdata_o       (hash_pdata),
    .pdata_valid_o (hash_valid),
    .pdata_ready_i (hash_ready)
  );

  head_table head_stage (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .pdata_in_i        (hash_pdata),
    .pdata_in_valid_i  (hash_valid),
    .pdata_in_ready_o  (hash_ready),
    .pdata_out_o       (head_pdata),
    .pdata_out_valid_o (head_valid),
    .pdata_out_ready_i (head_ready),
    .tbl_wr_en_i       (tbl_wr_en),
    .tbl_wr_bucket_i   (tbl_wr_bucket),
    .tbl_wr_entry_i    (tbl_wr_entry),
    .tbl_wr_valid_i    (tbl_wr_valid)
  );

  ht_result_calc result_stage (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .pdata_i         (head_pdata),
    .pdata_valid_i   (head_valid),
    .pdata_ready_o   (head_ready),
    .res_code_o      (res_code_o),
    .res_key_o       (res_key_o),
    .res_value_o     (res_value_o),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .tbl_wr_en_o     (tbl_wr_en),
    .tbl_wr_bucket_o (tbl_wr_bucket),
    .tbl_wr_entry_o  (tbl_wr_entry),
    .tbl_wr_valid_o  (tbl_wr_valid)
  );

endmodule

`default_nettype wire
